// File: files.f
+incdir+include
hdl/npu_pkg.sv
hdl/npu_ifs.sv
hdl/conv_ctrl.sv
hdl/operand_fetch.sv
hdl/mac_unit.sv
hdl/result_streamer.sv
hdl/npu_top.sv
tb/npu_tb.sv

// File: Makefile
# Verilator flow for the convolution engine

TOP = npu_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -f files.f --top-module $(TOP)

# pass only if the testbench printed its pass line
sim:
	verilator --binary --timing --timescale 1ns/1ps -Wno-fatal -f files.f \
		--top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qF ">>> PASS"

clean:
	rm -rf obj_dir

// File: tb/npu_tb.sv
/*
 * directed testbench for the convolution engine, golden model computed here
 * stops at the first error, run is bounded by a cycle counter
 */
`include "npu_consts.svh"

module npu_tb import npu_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    logic       s00_axis_aclk = 1'b0;
    logic       rst_i;
    pixel_t     s_axis_tdata_i;
    logic [9:0] s_axis_tuser_i;
    logic       s_axis_tvalid_i;
    logic       s_axis_tlast_i;
    logic       s_axis_tready_o;
    acc_t       m_axis_tdata_o;
    logic       m_axis_tvalid_o;
    logic       m_axis_tlast_o;
    logic       m_axis_tready_i;

    pixel_t      img_buf [`NPU_IMG_DEPTH];
    pixel_t      ker_buf [`NPU_KER_DEPTH];
    acc_t        exp_q[$];
    acc_t        got_data_q[$];
    logic        got_last_q[$];
    acc_t        ref_q[$];
    logic [31:0] rng = 32'he609;
    int          cycle_cnt = 0;
    int          stall_cnt = 0;

    // load, compute and stream cycles of one job
    function automatic int job_cycles(input int ir, input int ic, input int kr, input int kc);
        int outs;
        outs = (ir - kr + 1) * (ic - kc + 1);
        return ir * ic + kr * kc + outs * kr * kc + outs;
    endfunction

    localparam int TIMEOUT_CYCLES = 4 * (job_cycles(4, 4, 2, 2) + job_cycles(16, 16, 4, 4)
        + 2 * job_cycles(6, 6, 3, 3) + job_cycles(5, 7, 3, 2) + job_cycles(6, 6, 1, 1)) + 1000;

    npu_top u_dut (.*);

    always #20 s00_axis_aclk = ~s00_axis_aclk;

    // ************************************************************
    // helpers
    // ************************************************************
    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic pixel_t rand_pixel();
        rng = xorshift(rng);
        return pixel_t'(rng[7:0]);
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "run stopped on first error");
    endtask

    task automatic check_acc(input string name, input acc_t got, input acc_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Mismatch %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("Mismatch %s: got %h, expected %h", name, got, exp));
        end
    endtask

    always @(posedge s00_axis_aclk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            abort_run($sformatf("timeout, tests did not finish in %0d cycles", TIMEOUT_CYCLES));
        end
    end

    // ************************************************************
    // stimulus and golden model
    // ************************************************************
    // dimensions go on beat 0 only with rows in the upper bits
    task automatic send_frame(input int rows, input int cols, input bit to_kernel);
        int n;
        n = rows * cols;
        for (int i = 0; i < n; i++) begin
            s_axis_tdata_i  = to_kernel ? ker_buf[i] : img_buf[i];
            s_axis_tuser_i  = (i == 0) ? {dim_t'(rows), dim_t'(cols)} : 10'd0;
            s_axis_tlast_i  = (i == n - 1);
            s_axis_tvalid_i = 1'b1;
            do @(negedge s00_axis_aclk); while (!s_axis_tready_o);
            @(posedge s00_axis_aclk);
            #2;
        end
        s_axis_tvalid_i = 1'b0;
        s_axis_tlast_i  = 1'b0;
        s_axis_tuser_i  = 10'd0;
    endtask

    // valid convolution with stride 1 and row-major outputs
    task automatic golden_conv(input int ir, input int ic, input int kr, input int kc);
        int sum;
        exp_q.delete();
        for (int orow = 0; orow <= ir - kr; orow++) begin
            for (int ocol = 0; ocol <= ic - kc; ocol++) begin
                sum = 0;
                for (int r = 0; r < kr; r++) begin
                    for (int c = 0; c < kc; c++) begin
                        sum += int'(img_buf[(orow + r) * ic + ocol + c])
                             * int'(ker_buf[r * kc + c]);
                    end
                end
                exp_q.push_back(acc_t'(sum));
            end
        end
    endtask

    // beats are taken until tlast; stall drops tready on random cycles
    task automatic collect_outputs(input bit stall);
        bit done;
        done = 1'b0;
        stall_cnt = 0;
        got_data_q.delete();
        got_last_q.delete();
        while (!done) begin
            if (stall) begin
                rng = xorshift(rng);
                m_axis_tready_i = rng[4];
            end else begin
                m_axis_tready_i = 1'b1;
            end
            @(negedge s00_axis_aclk);
            if (m_axis_tvalid_o && !m_axis_tready_i) begin
                stall_cnt++;
            end
            if (m_axis_tvalid_o && m_axis_tready_i) begin
                got_data_q.push_back(m_axis_tdata_o);
                got_last_q.push_back(m_axis_tlast_o);
                done = m_axis_tlast_o;
                if (got_data_q.size() > exp_q.size()) begin
                    abort_run("more output beats than expected, tlast missing");
                end
            end
            @(posedge s00_axis_aclk);
            #2;
        end
        m_axis_tready_i = 1'b1;
    endtask

    task automatic run_conv(input int ir, input int ic, input int kr, input int kc,
                            input bit stall);
        golden_conv(ir, ic, kr, kc);
        send_frame(ir, ic, 1'b0);
        send_frame(kr, kc, 1'b1);
        collect_outputs(stall);
        if (got_data_q.size() != exp_q.size()) begin
            abort_run($sformatf("expected %0d output beats but tlast came after %0d",
                                exp_q.size(), got_data_q.size()));
        end
        foreach (exp_q[k]) begin
            check_acc("m_axis_tdata_o", got_data_q[k], exp_q[k]);
            check_bit("m_axis_tlast_o", got_last_q[k], k == exp_q.size() - 1);
        end
        // nothing may follow the final beat
        @(negedge s00_axis_aclk);
        check_bit("m_axis_tvalid_o", m_axis_tvalid_o, 1'b0);
        @(posedge s00_axis_aclk);
        #2;
    endtask

    // ************************************************************
    // directed tests
    // ************************************************************
    task automatic test_reset_state();
        @(negedge s00_axis_aclk);
        check_bit("m_axis_tvalid_o", m_axis_tvalid_o, 1'b0);
        check_bit("m_axis_tlast_o", m_axis_tlast_o, 1'b0);
        check_bit("s_axis_tready_o", s_axis_tready_o, 1'b1);
        @(posedge s00_axis_aclk);
        #2;
    endtask

    task automatic test_small_known();
        for (int i = 0; i < 16; i++) begin
            img_buf[i] = pixel_t'(i + 1);
        end
        ker_buf[0] = 8'sd1;
        ker_buf[1] = 8'sd2;
        ker_buf[2] = -8'sd1;
        ker_buf[3] = 8'sd3;
        run_conv(4, 4, 2, 2, 1'b0);
    endtask

    // top-left window all -128 gives the largest possible sum
    task automatic test_signed_extremes();
        for (int i = 0; i < 256; i++) begin
            rng = xorshift(rng);
            img_buf[i] = rng[0] ? 8'sd127 : -8'sd128;
            if ((i / 16) < 4 && (i % 16) < 4) begin
                img_buf[i] = -8'sd128;
            end
        end
        for (int i = 0; i < 16; i++) begin
            ker_buf[i] = -8'sd128;
        end
        run_conv(16, 16, 4, 4, 1'b0);
    endtask

    task automatic test_back_pressure();
        for (int i = 0; i < 36; i++) begin
            img_buf[i] = rand_pixel();
        end
        for (int i = 0; i < 9; i++) begin
            ker_buf[i] = rand_pixel();
        end
        run_conv(6, 6, 3, 3, 1'b0);
        ref_q = got_data_q;
        run_conv(6, 6, 3, 3, 1'b1);
        if (stall_cnt == 0) begin
            abort_run("back-pressure never held a valid output beat");
        end
        foreach (ref_q[k]) begin
            check_acc("m_axis_tdata_o", got_data_q[k], ref_q[k]);
        end
    endtask

    task automatic test_back_to_back();
        for (int i = 0; i < 35; i++) begin
            img_buf[i] = rand_pixel();
        end
        for (int i = 0; i < 6; i++) begin
            ker_buf[i] = rand_pixel();
        end
        run_conv(5, 7, 3, 2, 1'b0);
        for (int i = 0; i < 36; i++) begin
            img_buf[i] = rand_pixel();
        end
        ker_buf[0] = -8'sd7;
        run_conv(6, 6, 1, 1, 1'b0);
        // with a 1x1 kernel each output is just pixel times weight
        foreach (got_data_q[k]) begin
            check_acc("m_axis_tdata_o", got_data_q[k], acc_t'(int'(img_buf[k]) * -7));
        end
    endtask

    initial begin
        rst_i           = 1'b1;
        s_axis_tdata_i  = '0;
        s_axis_tuser_i  = 10'd0;
        s_axis_tvalid_i = 1'b0;
        s_axis_tlast_i  = 1'b0;
        m_axis_tready_i = 1'b1;
        repeat (16) @(posedge s00_axis_aclk);
        #2;
        rst_i = 1'b0;

        test_reset_state();
        test_small_known();
        test_signed_extremes();
        test_back_pressure();
        test_back_to_back();

        $display(">>> PASS");
        $finish;
    end

endmodule

// File: hdl/npu_top.sv
/*
 * convolution engine top, image frame then kernel frame in, results out
 * tuser carries rows (upper 5 bits) and columns (lower 5) on a frame's first beat
 * kernel no larger than the image is assumed, not checked
 */
module npu_top (
    input  logic            s00_axis_aclk,
    input  logic            rst_i,

    // input stream
    input  npu_pkg::pixel_t s_axis_tdata_i,
    input  logic [9:0]      s_axis_tuser_i,
    input  logic            s_axis_tvalid_i,
    input  logic            s_axis_tlast_i,
    output logic            s_axis_tready_o,

    // output stream
    output npu_pkg::acc_t   m_axis_tdata_o,
    output logic            m_axis_tvalid_o,
    output logic            m_axis_tlast_o,
    input  logic            m_axis_tready_i
);

    load_if    ld_bus ();
    window_if  win_bus ();
    operand_if op_bus ();

    logic          res_valid;
    npu_pkg::acc_t res_data;
    logic          stream_start;
    logic          stream_done;

    conv_ctrl u_ctrl (
        .s00_axis_aclk   (s00_axis_aclk),
        .rst_i           (rst_i),
        .s_axis_tdata_i  (s_axis_tdata_i),
        .s_axis_tuser_i  (s_axis_tuser_i),
        .s_axis_tvalid_i (s_axis_tvalid_i),
        .s_axis_tlast_i  (s_axis_tlast_i),
        .s_axis_tready_o (s_axis_tready_o),
        .ld              (ld_bus.ctrl),
        .win             (win_bus.ctrl),
        .stream_start_o  (stream_start),
        .stream_done_i   (stream_done)
    );

    operand_fetch u_fetch (
        .s00_axis_aclk (s00_axis_aclk),
        .ld            (ld_bus.buffer),
        .win           (win_bus.buffer),
        .op            (op_bus.source)
    );

    mac_unit u_mac (
        .s00_axis_aclk (s00_axis_aclk),
        .rst_i         (rst_i),
        .op            (op_bus.sink),
        .res_valid_o   (res_valid),
        .res_data_o    (res_data)
    );

    result_streamer u_out (
        .s00_axis_aclk   (s00_axis_aclk),
        .rst_i           (rst_i),
        .res_valid_i     (res_valid),
        .res_data_i      (res_data),
        .stream_start_i  (stream_start),
        .stream_done_o   (stream_done),
        .m_axis_tdata_o  (m_axis_tdata_o),
        .m_axis_tvalid_o (m_axis_tvalid_o),
        .m_axis_tlast_o  (m_axis_tlast_o),
        .m_axis_tready_i (m_axis_tready_i)
    );

endmodule

// File: hdl/result_streamer.sv
/*
 * result buffer and AXI4-Stream master with back-pressure
 * up to 256 results per job, tlast on the final one
 */
`include "npu_consts.svh"

module result_streamer import npu_pkg::*; (
    input  logic s00_axis_aclk,
    input  logic rst_i,
    input  logic res_valid_i,
    input  acc_t res_data_i,
    input  logic stream_start_i,
    output logic stream_done_o,
    output acc_t m_axis_tdata_o,
    output logic m_axis_tvalid_o,
    output logic m_axis_tlast_o,
    input  logic m_axis_tready_i
);

    // one extra bit so a full buffer of 256 can be counted
    localparam int CNT_W = $clog2(`NPU_RES_DEPTH) + 1;

    acc_t             res_mem [`NPU_RES_DEPTH];
    logic [CNT_W-1:0] wr_cnt;
    logic [CNT_W-1:0] rd_cnt;
    logic             active;
    logic             xfer;
    logic             load;

    assign xfer = m_axis_tvalid_o && m_axis_tready_i;
    assign load = (active || stream_start_i) && (rd_cnt != wr_cnt)
               && (!m_axis_tvalid_o || m_axis_tready_i);

    always_ff @(posedge s00_axis_aclk) begin
        if (res_valid_i) begin
            res_mem[buf_addr_t'(wr_cnt)] <= res_data_i;
        end
        if (load) begin
            m_axis_tdata_o <= res_mem[buf_addr_t'(rd_cnt)];
        end
    end

    // ************************************************************
    // pointers and output handshake
    // ************************************************************
    always_ff @(posedge s00_axis_aclk) begin
        if (rst_i) begin
            wr_cnt          <= '0;
            rd_cnt          <= '0;
            active          <= 1'b0;
            m_axis_tvalid_o <= 1'b0;
            m_axis_tlast_o  <= 1'b0;
            stream_done_o   <= 1'b0;
        end else begin
            stream_done_o <= xfer && m_axis_tlast_o;
            if (stream_start_i) begin
                active <= 1'b1;
            end
            if (res_valid_i) begin
                wr_cnt <= wr_cnt + 1'b1;
            end
            if (load) begin
                rd_cnt          <= rd_cnt + 1'b1;
                m_axis_tvalid_o <= 1'b1;
                m_axis_tlast_o  <= (rd_cnt == wr_cnt - 1'b1);
            end else if (xfer) begin
                m_axis_tvalid_o <= 1'b0;
                m_axis_tlast_o  <= 1'b0;
            end
            // job finished, buffer free for the next one
            if (xfer && m_axis_tlast_o) begin
                wr_cnt <= '0;
                rd_cnt <= '0;
                active <= 1'b0;
            end
        end
    end

    a_hold_under_stall: assert property (@(posedge s00_axis_aclk) disable iff (rst_i)
        m_axis_tvalid_o && !m_axis_tready_i |=> m_axis_tvalid_o
            && $stable(m_axis_tdata_o) && $stable(m_axis_tlast_o));

endmodule

// File: hdl/mac_unit.sv
/*
 * signed multiply-accumulate over one kernel window
 * the sum is valid for one cycle after the last tap
 */
module mac_unit import npu_pkg::*; (
    input  logic     s00_axis_aclk,
    input  logic     rst_i,
    operand_if.sink  op,
    output logic     res_valid_o,
    output acc_t     res_data_o
);

    logic signed [2*$bits(pixel_t)-1:0] product;
    acc_t                               acc;

    assign product = op.pixel * op.weight;

    // first tap restarts the sum
    always_ff @(posedge s00_axis_aclk) begin
        if (op.valid) begin
            if (op.first) begin
                acc <= acc_t'(product);
            end else begin
                acc <= acc + acc_t'(product);
            end
        end
    end

    always_ff @(posedge s00_axis_aclk) begin
        if (rst_i) begin
            res_valid_o <= 1'b0;
        end else begin
            res_valid_o <= op.valid && op.last;
        end
    end

    // holds the finished window while the next one starts
    assign res_data_o = acc;

    a_markers_need_valid: assert property (@(posedge s00_axis_aclk) disable iff (rst_i)
        (op.first || op.last) |-> op.valid);

endmodule

// File: hdl/operand_fetch.sv
/*
 * image and kernel buffers with window addressing
 * both reads are registered, so operands trail the window by one cycle
 */
`include "npu_consts.svh"

module operand_fetch import npu_pkg::*; (
    input  logic      s00_axis_aclk,
    load_if.buffer    ld,
    window_if.buffer  win,
    operand_if.source op
);

    pixel_t    img_mem [`NPU_IMG_DEPTH];
    pixel_t    ker_mem [`NPU_KER_DEPTH];
    buf_addr_t img_addr;
    ker_addr_t ker_addr;

    // frames are stored row-major from address 0
    always_ff @(posedge s00_axis_aclk) begin
        if (ld.img_we) begin
            img_mem[ld.wr_addr] <= ld.wr_data;
        end
        if (ld.ker_we) begin
            ker_mem[ker_addr_t'(ld.wr_addr)] <= ld.wr_data;
        end
    end

    // (out_row + ker_row) * img_cols + out_col + ker_col
    always_comb begin
        img_addr = buf_addr_t'(win.out_row + win.ker_row) * buf_addr_t'(win.img_cols)
                 + buf_addr_t'(win.out_col) + buf_addr_t'(win.ker_col);
        ker_addr = ker_addr_t'(win.ker_row) * ker_addr_t'(win.ker_cols)
                 + ker_addr_t'(win.ker_col);
    end

    always_ff @(posedge s00_axis_aclk) begin
        op.pixel  <= img_mem[img_addr];
        op.weight <= ker_mem[ker_addr];
    end

    // markers follow the data
    always_ff @(posedge s00_axis_aclk) begin
        op.valid <= win.valid;
        op.first <= win.first;
        op.last  <= win.last;
    end

endmodule

// File: hdl/conv_ctrl.sv
/*
 * job control: load image, load kernel, sweep windows, drain, stream
 * dimensions are taken from tuser on the first beat of each frame
 * input is closed from the end of the kernel frame until the stream is done
 */
module conv_ctrl import npu_pkg::*; (
    input  logic       s00_axis_aclk,
    input  logic       rst_i,
    input  pixel_t     s_axis_tdata_i,
    input  logic [9:0] s_axis_tuser_i,
    input  logic       s_axis_tvalid_i,
    input  logic       s_axis_tlast_i,
    output logic       s_axis_tready_o,
    load_if.ctrl       ld,
    window_if.ctrl     win,
    output logic       stream_start_o,
    input  logic       stream_done_i
);

    ctrl_state_t state;
    logic        beat;
    logic        frame_first;
    buf_addr_t   wr_addr_q;
    logic        drain_cnt;

    dim_t tuser_rows, tuser_cols;
    dim_t img_rows, img_cols, ker_rows, ker_cols;
    dim_t out_rows, out_cols;
    dim_t out_row, out_col, ker_row, ker_col;
    logic ker_col_end, ker_row_end, out_col_end, out_row_end;
    logic win_final;

    // ************************************************************
    // input side
    // ************************************************************
    assign s_axis_tready_o = (state == LOAD_IMG) || (state == LOAD_KER);
    assign beat = s_axis_tvalid_i && s_axis_tready_o;
    assign {tuser_rows, tuser_cols} = s_axis_tuser_i;

    assign ld.img_we  = beat && (state == LOAD_IMG);
    assign ld.ker_we  = beat && (state == LOAD_KER);
    assign ld.wr_addr = wr_addr_q;
    assign ld.wr_data = s_axis_tdata_i;

    // beat counter restarts at every tlast
    always_ff @(posedge s00_axis_aclk) begin
        if (rst_i) begin
            wr_addr_q   <= '0;
            frame_first <= 1'b1;
        end else if (beat) begin
            wr_addr_q   <= s_axis_tlast_i ? '0 : wr_addr_q + 1'b1;
            frame_first <= s_axis_tlast_i;
        end
    end

    always_ff @(posedge s00_axis_aclk) begin
        if (beat && frame_first) begin
            if (state == LOAD_IMG) begin
                img_rows <= tuser_rows;
                img_cols <= tuser_cols;
            end else begin
                ker_rows <= tuser_rows;
                ker_cols <= tuser_cols;
            end
        end
    end

    // ************************************************************
    // window sweep with kernel column innermost
    // ************************************************************
    assign out_rows    = img_rows - ker_rows + 1'b1;
    assign out_cols    = img_cols - ker_cols + 1'b1;
    assign ker_col_end = (ker_col == ker_cols - 1'b1);
    assign ker_row_end = (ker_row == ker_rows - 1'b1);
    assign out_col_end = (out_col == out_cols - 1'b1);
    assign out_row_end = (out_row == out_rows - 1'b1);

    assign win.valid    = (state == CONV);
    assign win.first    = win.valid && (ker_row == '0) && (ker_col == '0);
    assign win.last     = win.valid && ker_row_end && ker_col_end;
    assign win.out_row  = out_row;
    assign win.out_col  = out_col;
    assign win.ker_row  = ker_row;
    assign win.ker_col  = ker_col;
    assign win.img_cols = img_cols;
    assign win.ker_cols = ker_cols;
    assign win_final    = win.last && out_col_end && out_row_end;

    // all counters wrap to zero on the final tap so the next job starts clean
    always_ff @(posedge s00_axis_aclk) begin
        if (rst_i) begin
            out_row <= '0;
            out_col <= '0;
            ker_row <= '0;
            ker_col <= '0;
        end else if (state == CONV) begin
            ker_col <= ker_col_end ? '0 : ker_col + 1'b1;
            if (ker_col_end) begin
                ker_row <= ker_row_end ? '0 : ker_row + 1'b1;
                if (ker_row_end) begin
                    out_col <= out_col_end ? '0 : out_col + 1'b1;
                    if (out_col_end) begin
                        out_row <= out_row_end ? '0 : out_row + 1'b1;
                    end
                end
            end
        end
    end

    // ************************************************************
    // FSM
    // ************************************************************
    always_ff @(posedge s00_axis_aclk) begin
        if (rst_i) begin
            state          <= LOAD_IMG;
            drain_cnt      <= 1'b0;
            stream_start_o <= 1'b0;
        end else begin
            stream_start_o <= 1'b0;
            case (state)
                LOAD_IMG: if (beat && s_axis_tlast_i) state <= LOAD_KER;
                LOAD_KER: if (beat && s_axis_tlast_i) state <= CONV;
                CONV:     if (win_final) state <= DRAIN;
                DRAIN: begin
                    // two cycles so the last sum reaches the result buffer
                    drain_cnt <= ~drain_cnt;
                    if (drain_cnt) begin
                        state          <= STREAM;
                        stream_start_o <= 1'b1;
                    end
                end
                STREAM:   if (stream_done_i) state <= LOAD_IMG;
                default:  state <= LOAD_IMG;
            endcase
        end
    end

    a_ker_col_range: assert property (@(posedge s00_axis_aclk) disable iff (rst_i)
        win.valid |-> win.ker_col < win.ker_cols);

    // once closed after the kernel frame, input reopens only on stream done
    a_no_beat_outside_load: assert property (@(posedge s00_axis_aclk) disable iff (rst_i)
        !s_axis_tready_o && !stream_done_i |=> !s_axis_tready_o);

endmodule

// File: hdl/npu_ifs.sv
/*
 * internal buses of the convolution engine
 * all three are single-cycle and have no stall
 */

// buffer write port, one strobe per accepted input beat
interface load_if import npu_pkg::*; ();
    logic      img_we;
    logic      ker_we;
    buf_addr_t wr_addr;
    pixel_t    wr_data;

    modport ctrl (output img_we, ker_we, wr_addr, wr_data);
    modport buffer (input img_we, ker_we, wr_addr, wr_data);
endinterface

// one kernel tap of one output window per clock
interface window_if import npu_pkg::*; ();
    logic valid;
    logic first;
    logic last;
    dim_t out_row;
    dim_t out_col;
    dim_t ker_row;
    dim_t ker_col;
    dim_t img_cols;
    dim_t ker_cols;

    modport ctrl (
        output valid, first, last, out_row, out_col, ker_row, ker_col, img_cols, ker_cols
    );
    modport buffer (
        input valid, first, last, out_row, out_col, ker_row, ker_col, img_cols, ker_cols
    );
endinterface

// operand pair for the MAC, window markers delayed to match
interface operand_if import npu_pkg::*; ();
    logic   valid;
    logic   first;
    logic   last;
    pixel_t pixel;
    pixel_t weight;

    modport source (output valid, first, last, pixel, weight);
    modport sink (input valid, first, last, pixel, weight);
endinterface

// File: hdl/npu_pkg.sv
/*
 * types of the convolution engine
 * address widths follow the buffer depths in npu_consts.svh
 */
`include "npu_consts.svh"

package npu_pkg;

    // signed pixel or weight
    typedef logic signed [`NPU_DATA_W-1:0] pixel_t;

    // product sum and output word
    typedef logic signed [`NPU_ACC_W-1:0] acc_t;

    // rows or columns
    typedef logic [`NPU_DIM_W-1:0] dim_t;

    // image and result buffer address
    typedef logic [$clog2(`NPU_IMG_DEPTH)-1:0] buf_addr_t;

    // kernel buffer address
    typedef logic [$clog2(`NPU_KER_DEPTH)-1:0] ker_addr_t;

    // control flow, one job per pass
    typedef enum logic [2:0] {
        LOAD_IMG,
        LOAD_KER,
        CONV,
        DRAIN,
        STREAM
    } ctrl_state_t;

endpackage

// File: include/npu_consts.svh
/*
 * sizes of the convolution engine, shared by package and RTL
 * image up to 16x16, kernel up to 4x4, one result per output pixel
 * changing a depth also changes the address types in npu_pkg
 */
`ifndef NPU_CONSTS_SVH
`define NPU_CONSTS_SVH

// pixel and weight width, signed
`define NPU_DATA_W 8

// result width, wide enough for 16 taps of extreme values
`define NPU_ACC_W 24

// row or column count, 0..16
`define NPU_DIM_W 5

// buffer depths
`define NPU_IMG_DEPTH 256
`define NPU_KER_DEPTH 16
`define NPU_RES_DEPTH 256

`endif
